/* cam2_downscaler.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module cam2_downscaler (
   input  logic                      clk,
   input  logic                      rst,
   input  dual_cam_pkg::merge_mode_e merge_mode_i,
   input  dual_cam_pkg::pixel_t      pixel_in2_i,
   input  logic                      pixel_in2_valid_i,
   input  logic                      pixel_in2_rready_i,
   input  logic                      fifo_prog_full_i,
   output logic                      req_scaling_o,
   output logic                      fifo_we_o,
   output dual_cam_pkg::pixel_t      fifo_wdata_o
);

   import dual_cam_pkg::*;

   coord_x_t x2;
   coord_y_t y2;
   logic     keep_col;
   logic     keep_row;

   // Tracks where the current camera 2 pixel sits in its frame
   raster_counter u_cam2_cnt (
      .clk        (clk),
      .rst        (rst),
      .advance_i  (pixel_in2_valid_i),
      .x_o        (x2),
      .y_o        (y2),
      .line_end_o ()
   );

   // Camera 2 keeps streaming until the FIFO nears full
   // The spare entries above prog-full absorb the pixel already in flight
   assign req_scaling_o = pixel_in2_rready_i && !fifo_prog_full_i;

   ////////////////////////////////////////
   // Nearest-neighbour pixel skipping
   ////////////////////////////////////////

   // One pixel survives out of each 4x4 block
   assign keep_col = ((x2 % `DC_SCALE) == `DC_SKIP_PHASE);
   assign keep_row = ((y2 % `DC_SCALE) == `DC_SKIP_PHASE);

   // Write in the same cycle as the camera 2 valid, overlay mode only
   assign fifo_we_o = (merge_mode_i == MERGE_OVERLAY) && pixel_in2_valid_i &&
                      keep_col && keep_row;

   // The kept pixel goes in untouched
   assign fifo_wdata_o = pixel_in2_i;

endmodule

/* dual_cam_checker.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module dual_cam_checker (
   input  logic                      clk,
   input  logic                      rst,
   input  dual_cam_pkg::merge_mode_e mode_i,
   input  dual_cam_pkg::pixel_t      pixel_out_i,
   input  logic                      pixel_out_valid_i,
   input  logic                      pixel_out_wready_i,
   input  logic                      pixel_in2_rready_i,
   input  logic                      pixel_in1_req_i,
   input  logic                      pixel_in2_req_i,
   input  logic                      fifo_we_i,
   input  logic                      fifo_re_i,
   input  logic                      fifo_overflow_i,
   input  logic                      fifo_underflow_i
);

   import dual_cam_pkg::*;

   localparam int W         = `DC_IMG_WIDTH;
   localparam int FRAME_PIX = `DC_IMG_WIDTH * `DC_IMG_HEIGHT;

   // Camera frames of the running test, written by the testbench
   pixel_t frame1 [FRAME_PIX];
   pixel_t frame2 [FRAME_PIX];

   // Per-frame counts, cleared by the reset ahead of each test
   int out_count;
   int wr_count;
   int rd_count;
   int ovf_count;
   int unf_count;
   int test_errs    = 0;
   int total_errs   = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   // Expected output pixel at raster position idx
   function automatic pixel_t expected_pixel(input int idx);
      int row;
      int col;
      int src;
      row = idx / W;
      col = idx % W;
      if (mode_i == MERGE_SPLIT) begin
         // Left half from camera 1, right half from camera 2
         return (col < W / 2) ? frame1[idx] : frame2[idx];
      end
      if (row >= `DC_OVL_Y_START && row < `DC_OVL_Y_END &&
          col >= `DC_OVL_X_START && col < `DC_OVL_X_END) begin
         // Window pixel maps to the kept pixel of its 4x4 block in camera 2
         src = (`DC_SCALE * (row - `DC_OVL_Y_START) + `DC_SKIP_PHASE) * W +
               `DC_SCALE * (col - `DC_OVL_X_START) + `DC_SKIP_PHASE;
         return frame2[src];
      end
      return frame1[idx];
   endfunction

   ////////////////////////////////////////
   // Output comparison and strobe counts
   ////////////////////////////////////////

   // Outputs are all settled by the falling edge
   always @(negedge clk) begin
      // Requests honour back-pressure at all times, reset included
      if (pixel_in1_req_i && !pixel_out_wready_i) begin
         $display("error at %0t: camera 1 was requested while the output was not ready",
                  $time);
         test_errs++;
      end
      if (pixel_in2_req_i && (!pixel_in2_rready_i ||
                              (mode_i == MERGE_SPLIT && !pixel_out_wready_i))) begin
         $display("error at %0t: camera 2 was requested while it or the output was not ready",
                  $time);
         test_errs++;
      end
      if (rst) begin
         out_count = 0;
         wr_count  = 0;
         rd_count  = 0;
         ovf_count = 0;
         unf_count = 0;
      end else begin
         if (pixel_out_valid_i) begin
            if (out_count >= FRAME_PIX) begin
               $display("error at %0t: output pixel beyond the end of the frame", $time);
               test_errs++;
            end else if (pixel_out_i !== expected_pixel(out_count)) begin
               $display("mismatch at %0t: pixel_out_o expected %02h got %02h (pixel %0d)",
                        $time, expected_pixel(out_count), pixel_out_i, out_count);
               test_errs++;
            end
            out_count++;
         end
         if (fifo_we_i) wr_count++;
         if (fifo_re_i) rd_count++;
         if (fifo_overflow_i) ovf_count++;
         if (fifo_underflow_i) unf_count++;
      end
   end

   // Closes one test and prints its result line
   task automatic report_test(input int num, input string name,
                              input int exp_writes, input int exp_reads);
      if (out_count != FRAME_PIX) begin
         $display("mismatch at %0t: pixel_out_valid_o count expected %0d got %0d",
                  $time, FRAME_PIX, out_count);
         test_errs++;
      end
      if (wr_count != exp_writes) begin
         $display("mismatch at %0t: fifo_we_o count expected %0d got %0d",
                  $time, exp_writes, wr_count);
         test_errs++;
      end
      if (rd_count != exp_reads) begin
         $display("mismatch at %0t: fifo_re_o count expected %0d got %0d",
                  $time, exp_reads, rd_count);
         test_errs++;
      end
      if (ovf_count != 0 || unf_count != 0) begin
         $display("test %0d: FIFO overflow or underflow strobe was raised", num);
         test_errs++;
      end
      if (test_errs == 0) begin
         $display("test %0d (%s): ok", num, name);
         tests_passed++;
      end else begin
         $display("test %0d (%s): FAILED with %0d errors", num, name, test_errs);
         tests_failed++;
      end
      total_errs += test_errs;
      test_errs = 0;
   endtask

endmodule

/* dual_cam_consts.svh */
`ifndef DUAL_CAM_CONSTS_SVH
`define DUAL_CAM_CONSTS_SVH

////////////////////////////////////////
// Frame geometry
////////////////////////////////////////

// Kept small so that a whole frame simulates quickly
`define DC_IMG_WIDTH      16
`define DC_IMG_HEIGHT     16

// Camera 2 is shrunk by this factor in each direction
`define DC_SCALE          4
`define DC_SCALED_WIDTH   (`DC_IMG_WIDTH / `DC_SCALE)
`define DC_SCALED_HEIGHT  (`DC_IMG_HEIGHT / `DC_SCALE)

////////////////////////////////////////
// Overlay window, ends are exclusive
////////////////////////////////////////

`define DC_OVL_X_START    (`DC_IMG_WIDTH - `DC_SCALED_WIDTH - 2)
`define DC_OVL_Y_START    2
`define DC_OVL_X_END      (`DC_OVL_X_START + `DC_SCALED_WIDTH)
`define DC_OVL_Y_END      (`DC_OVL_Y_START + `DC_SCALED_HEIGHT)

// Position kept inside every 4x4 block of camera 2
`define DC_SKIP_PHASE     2

// Overlay FIFO size and the level that throttles camera 2
`define DC_FIFO_DEPTH     16
`define DC_FIFO_PROG_FULL 12

`endif

/* dual_cam_pkg.sv */
`include "dual_cam_consts.svh"

package dual_cam_pkg;

   // One grayscale sample from either camera
   typedef logic [7:0] pixel_t;

   // One spare bit on each coordinate so an overrun past the frame edge is visible
   typedef logic [$clog2(`DC_IMG_WIDTH):0]  coord_x_t;
   typedef logic [$clog2(`DC_IMG_HEIGHT):0] coord_y_t;

   // Split puts camera 1 left and camera 2 right
   // Overlay drops a shrunk camera 2 into a window of camera 1
   typedef enum logic {
      MERGE_SPLIT   = 1'b0,
      MERGE_OVERLAY = 1'b1
   } merge_mode_e;

endpackage

/* dual_cam_top.sv */
`timescale 1ns/1ps

module dual_cam_top (
   input  logic                      clk,
   input  logic                      rst,
   input  dual_cam_pkg::merge_mode_e merge_mode_i,
   input  logic                      pixel_in1_rready_i,
   input  dual_cam_pkg::pixel_t      pixel_in1_i,
   input  logic                      pixel_in1_valid_i,
   input  logic                      pixel_in2_rready_i,
   input  dual_cam_pkg::pixel_t      pixel_in2_i,
   input  logic                      pixel_in2_valid_i,
   input  logic                      pixel_out_wready_i,
   output logic                      pixel_in1_req_o,
   output logic                      pixel_in2_req_o,
   output dual_cam_pkg::pixel_t      pixel_out_o,
   output logic                      pixel_out_valid_o,
   output logic                      fifo_overflow_o,
   output logic                      fifo_underflow_o,
   output logic                      fifo_we_o,
   output logic                      fifo_re_o
);

   import dual_cam_pkg::*;

   pixel_t fifo_wdata;
   logic   fifo_prog_full;
   logic   req2_scaling;

   overlay_fifo_if fifo_rd_if ();

   // Read strobe is exported for observation
   assign fifo_re_o = fifo_rd_if.rd_en;

   cam2_downscaler u_downscaler (
      .clk                (clk),
      .rst                (rst),
      .merge_mode_i       (merge_mode_i),
      .pixel_in2_i        (pixel_in2_i),
      .pixel_in2_valid_i  (pixel_in2_valid_i),
      .pixel_in2_rready_i (pixel_in2_rready_i),
      .fifo_prog_full_i   (fifo_prog_full),
      .req_scaling_o      (req2_scaling),
      .fifo_we_o          (fifo_we_o),
      .fifo_wdata_o       (fifo_wdata)
   );

   overlay_fifo u_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en_i     (fifo_we_o),
      .wr_data_i   (fifo_wdata),
      .prog_full_o (fifo_prog_full),
      .overflow_o  (fifo_overflow_o),
      .underflow_o (fifo_underflow_o),
      .rd          (fifo_rd_if.fifo_side)
   );

   // The merger also picks the camera 2 request for the active mode
   frame_merger u_merger (
      .clk                (clk),
      .rst                (rst),
      .merge_mode_i       (merge_mode_i),
      .pixel_in1_rready_i (pixel_in1_rready_i),
      .pixel_in1_i        (pixel_in1_i),
      .pixel_in1_valid_i  (pixel_in1_valid_i),
      .pixel_in2_rready_i (pixel_in2_rready_i),
      .pixel_in2_i        (pixel_in2_i),
      .pixel_in2_valid_i  (pixel_in2_valid_i),
      .pixel_out_wready_i (pixel_out_wready_i),
      .req2_scaling_i     (req2_scaling),
      .pixel_in1_req_o    (pixel_in1_req_o),
      .pixel_in2_req_o    (pixel_in2_req_o),
      .rd                 (fifo_rd_if.merger_side),
      .pixel_out_o        (pixel_out_o),
      .pixel_out_valid_o  (pixel_out_valid_o)
   );

endmodule

/* filelist.f */
+incdir+.
dual_cam_pkg.sv
overlay_fifo_if.sv
raster_counter.sv
cam2_downscaler.sv
overlay_fifo.sv
frame_merger.sv
dual_cam_top.sv
dual_cam_checker.sv
tb_dual_cam.sv

/* frame_merger.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module frame_merger (
   input  logic                      clk,
   input  logic                      rst,
   input  dual_cam_pkg::merge_mode_e merge_mode_i,
   input  logic                      pixel_in1_rready_i,
   input  dual_cam_pkg::pixel_t      pixel_in1_i,
   input  logic                      pixel_in1_valid_i,
   input  logic                      pixel_in2_rready_i,
   input  dual_cam_pkg::pixel_t      pixel_in2_i,
   input  logic                      pixel_in2_valid_i,
   input  logic                      pixel_out_wready_i,
   input  logic                      req2_scaling_i,
   output logic                      pixel_in1_req_o,
   output logic                      pixel_in2_req_o,
   overlay_fifo_if.merger_side       rd,
   output dual_cam_pkg::pixel_t      pixel_out_o,
   output logic                      pixel_out_valid_o
);

   import dual_cam_pkg::*;

   coord_x_t x_req;
   coord_y_t y_req;
   coord_x_t x_val;
   logic     overlay;
   logic     in_window;
   logic     insert_done;
   logic     joint_req;
   logic     req1_overlay;
   pixel_t   merged;

   assign overlay = (merge_mode_i == MERGE_OVERLAY);

   // Position of the next pixel to be requested from camera 1
   raster_counter u_req_cnt (
      .clk        (clk),
      .rst        (rst),
      .advance_i  (pixel_in1_req_o),
      .x_o        (x_req),
      .y_o        (y_req),
      .line_end_o ()
   );

   // Position of the camera 1 pixel arriving now, one cycle behind the request
   raster_counter u_val_cnt (
      .clk        (clk),
      .rst        (rst),
      .advance_i  (pixel_in1_valid_i),
      .x_o        (x_val),
      .y_o        (),
      .line_end_o ()
   );

   ////////////////////////////////////////
   // Overlay window and requests
   ////////////////////////////////////////

   assign in_window = (x_req >= `DC_OVL_X_START) && (x_req < `DC_OVL_X_END) &&
                      (y_req >= `DC_OVL_Y_START) && (y_req < `DC_OVL_Y_END);

   // Set once the last window pixel has been pulled from the FIFO
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         insert_done <= 1'b0;
      end else if (rd.rd_en && (x_req == `DC_OVL_X_END - 1) &&
                   (y_req == `DC_OVL_Y_END - 1)) begin
         insert_done <= 1'b1;
      end
   end

   // Split mode pulls both cameras in lockstep
   assign joint_req = pixel_in1_rready_i && pixel_in2_rready_i && pixel_out_wready_i;

   // Camera 1 waits for overlay data until the window has been filled
   assign req1_overlay = pixel_in1_rready_i && pixel_out_wready_i &&
                         (!rd.empty || insert_done);

   // A window pixel always comes with a camera 1 request, so both land together
   assign rd.rd_en = overlay && pixel_in1_rready_i && pixel_out_wready_i &&
                     !rd.empty && in_window;

   assign pixel_in1_req_o = overlay ? req1_overlay : joint_req;
   assign pixel_in2_req_o = overlay ? req2_scaling_i : joint_req;

   ////////////////////////////////////////
   // Pixel selection and output register
   ////////////////////////////////////////

   // Right half in split mode is judged by the arriving pixel's column
   assign merged = (overlay && rd.rd_valid) ? rd.rd_data :
                   (!overlay && (x_val >= `DC_IMG_WIDTH / 2)) ? pixel_in2_i : pixel_in1_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pixel_out_valid_o <= 1'b0;
      end else begin
         pixel_out_valid_o <= pixel_in1_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (pixel_in1_valid_i) begin
         pixel_out_o <= merged;
      end
   end

   // Camera 1 data may only show up the cycle after it was asked for
   a_valid1_after_req : assert property (
      @(posedge clk) disable iff (rst)
      pixel_in1_valid_i |-> $past(pixel_in1_req_o)
   );

   // With the joint request both cameras answer in the same cycle
   a_split_valids_aligned : assert property (
      @(posedge clk) disable iff (rst)
      !overlay |-> (pixel_in2_valid_i == pixel_in1_valid_i)
   );

endmodule

/* overlay_fifo.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module overlay_fifo (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wr_en_i,
   input  dual_cam_pkg::pixel_t wr_data_i,
   output logic                 prog_full_o,
   output logic                 overflow_o,
   output logic                 underflow_o,
   overlay_fifo_if.fifo_side    rd
);

   import dual_cam_pkg::*;

   localparam int PTR_W = $clog2(`DC_FIFO_DEPTH);

   pixel_t           mem [`DC_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             full;
   logic             wr_ok;
   logic             rd_ok;

   assign full     = (count == `DC_FIFO_DEPTH);
   assign rd.empty = (count == 0);

   // Writes into a full buffer and reads of an empty one are dropped
   assign wr_ok = wr_en_i && !full;
   assign rd_ok = rd.rd_en && !rd.empty;

   // Throttle level for the camera 2 request
   assign prog_full_o = (count >= `DC_FIFO_PROG_FULL);

   ////////////////////////////////////////
   // Pointers, occupancy and strobes
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         rd.rd_valid <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         // Pointers wrap on their own since the depth is a power of two
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count       <= count + wr_ok - rd_ok;
         rd.rd_valid <= rd_ok;
         // Error strobes, one cycle per offending request
         overflow_o  <= wr_en_i && full;
         underflow_o <= rd.rd_en && rd.empty;
      end
   end

   ////////////////////////////////////////
   // Storage and read data
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data_i;
      end
      // Read data lines up with rd_valid in the next cycle
      if (rd_ok) begin
         rd.rd_data <= mem[rd_ptr];
      end
   end

   // The occupancy must stay within the buffer whatever both sides do
   a_count_bound : assert property (
      @(posedge clk) disable iff (rst)
      count <= `DC_FIFO_DEPTH
   );

endmodule

/* overlay_fifo_if.sv */
`timescale 1ns/1ps

interface overlay_fifo_if;

   import dual_cam_pkg::*;

   // Read request from the merger, honoured only when the FIFO holds data
   logic   rd_en;
   // Data comes back one cycle after an accepted read
   pixel_t rd_data;
   logic   rd_valid;
   // Live occupancy flag, the merger uses it to pace camera 1
   logic   empty;

   modport fifo_side (
      input  rd_en,
      output rd_data,
      output rd_valid,
      output empty
   );

   modport merger_side (
      output rd_en,
      input  rd_data,
      input  rd_valid,
      input  empty
   );

endinterface

/* raster_counter.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module raster_counter (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   advance_i,
   output dual_cam_pkg::coord_x_t x_o,
   output dual_cam_pkg::coord_y_t y_o,
   output logic                   line_end_o
);

   // Flags the last column of the line
   assign line_end_o = (x_o == `DC_IMG_WIDTH - 1);

   // Frame position, cleared by the reset that precedes each frame
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         x_o <= '0;
         y_o <= '0;
      end else if (advance_i) begin
         if (line_end_o) begin
            // Wrap to the start of the next line
            x_o <= '0;
            y_o <= y_o + 1'b1;
         end else begin
            x_o <= x_o + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // The wrap must always catch the column before the frame edge
   a_col_in_frame : assert property (
      @(posedge clk) disable iff (rst)
      x_o < `DC_IMG_WIDTH
   );

endmodule

/* tb_dual_cam.sv */
`timescale 1ns/1ps
`include "dual_cam_consts.svh"

module tb_dual_cam;

   import dual_cam_pkg::*;

   localparam int FRAME_PIX   = `DC_IMG_WIDTH * `DC_IMG_HEIGHT;
   localparam int KEPT_PIX    = `DC_SCALED_WIDTH * `DC_SCALED_HEIGHT;
   localparam int NUM_TESTS   = 4;
   // Five times the pixels of all frames together
   localparam int CYCLE_LIMIT = 5 * NUM_TESTS * FRAME_PIX;

   logic        clk;
   logic        rst;
   merge_mode_e mode;
   logic        in1_rready;
   pixel_t      in1_pixel;
   logic        in1_valid;
   logic        in2_rready;
   pixel_t      in2_pixel;
   logic        in2_valid;
   logic        out_wready;
   logic        in1_req;
   logic        in2_req;
   pixel_t      out_pixel;
   logic        out_valid;
   logic        fifo_ovf;
   logic        fifo_unf;
   logic        fifo_we;
   logic        fifo_re;
   integer      seed;
   int          cycles;
   int          t;

   ////////////////////////////////////////
   // Test table, one array per column
   ////////////////////////////////////////

   string       tab_name       [NUM_TESTS] = '{"split, always ready", "split, output stalls",
                                              "overlay, always ready", "overlay, camera 2 stalls"};
   merge_mode_e tab_mode       [NUM_TESTS] = '{MERGE_SPLIT, MERGE_SPLIT,
                                              MERGE_OVERLAY, MERGE_OVERLAY};
   // Random back-pressure on the output side and on camera 2
   logic        tab_stall_out  [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0};
   logic        tab_stall_cam2 [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};
   // Strobe counts expected over one frame
   int          tab_writes     [NUM_TESTS] = '{0, 0, KEPT_PIX, KEPT_PIX};
   int          tab_reads      [NUM_TESTS] = '{0, 0, KEPT_PIX, KEPT_PIX};

   dual_cam_top UUT (
      .clk                (clk),
      .rst                (rst),
      .merge_mode_i       (mode),
      .pixel_in1_rready_i (in1_rready),
      .pixel_in1_i        (in1_pixel),
      .pixel_in1_valid_i  (in1_valid),
      .pixel_in2_rready_i (in2_rready),
      .pixel_in2_i        (in2_pixel),
      .pixel_in2_valid_i  (in2_valid),
      .pixel_out_wready_i (out_wready),
      .pixel_in1_req_o    (in1_req),
      .pixel_in2_req_o    (in2_req),
      .pixel_out_o        (out_pixel),
      .pixel_out_valid_o  (out_valid),
      .fifo_overflow_o    (fifo_ovf),
      .fifo_underflow_o   (fifo_unf),
      .fifo_we_o          (fifo_we),
      .fifo_re_o          (fifo_re)
   );

   dual_cam_checker u_checker (
      .clk                (clk),
      .rst                (rst),
      .mode_i             (mode),
      .pixel_out_i        (out_pixel),
      .pixel_out_valid_i  (out_valid),
      .pixel_out_wready_i (out_wready),
      .pixel_in2_rready_i (in2_rready),
      .pixel_in1_req_i    (in1_req),
      .pixel_in2_req_i    (in2_req),
      .fifo_we_i          (fifo_we),
      .fifo_re_i          (fifo_re),
      .fifo_overflow_i    (fifo_ovf),
      .fifo_underflow_i   (fifo_unf)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Runs one frame through the DUT with both camera models answering requests
   task automatic apply_test(input int idx);
      int          i;
      int          n1;
      int          n2;
      logic        r1;
      logic        r2;
      logic [31:0] rnd;
      // Fresh random frames, kept in the checker for prediction
      for (i = 0; i < FRAME_PIX; i++) begin
         rnd = $random(seed);
         u_checker.frame1[i] = rnd[7:0];
         rnd = $random(seed);
         u_checker.frame2[i] = rnd[7:0];
      end
      // Cameras and output sink idle while reset is held
      @(posedge clk);
      #1;
      rst        = 1'b1;
      mode       = tab_mode[idx];
      in1_valid  = 1'b0;
      in2_valid  = 1'b0;
      in1_rready = 1'b0;
      in2_rready = 1'b0;
      out_wready = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst        = 1'b0;
      in1_rready = 1'b1;
      in2_rready = 1'b1;
      out_wready = 1'b1;
      n1 = 0;
      n2 = 0;
      while (u_checker.out_count < FRAME_PIX) begin
         // Requests are settled by the falling edge
         @(negedge clk);
         r1 = in1_req;
         r2 = in2_req;
         @(posedge clk);
         #1;
         // Each source answers one cycle after its request until its frame runs out
         in1_valid = r1 && (n1 < FRAME_PIX);
         in2_valid = r2 && (n2 < FRAME_PIX);
         if (in1_valid) begin
            in1_pixel = u_checker.frame1[n1];
            n1++;
         end
         if (in2_valid) begin
            in2_pixel = u_checker.frame2[n2];
            n2++;
         end
         rnd = $random(seed);
         out_wready = tab_stall_out[idx] ? rnd[0] : 1'b1;
         in2_rready = tab_stall_cam2[idx] ? rnd[1] : 1'b1;
      end
      u_checker.report_test(idx + 1, tab_name[idx], tab_writes[idx], tab_reads[idx]);
   endtask

   initial begin
      seed       = 32'haf1c;
      rst        = 1'b1;
      mode       = MERGE_SPLIT;
      in1_rready = 1'b0;
      in1_pixel  = '0;
      in1_valid  = 1'b0;
      in2_rready = 1'b0;
      in2_pixel  = '0;
      in2_valid  = 1'b0;
      out_wready = 1'b0;
      for (t = 0; t < NUM_TESTS; t++) begin
         apply_test(t);
      end
      $display("tests: %0d passed, %0d failed, %0d errors", u_checker.tests_passed,
               u_checker.tests_failed, u_checker.total_errs);
      if (u_checker.tests_failed == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog in case a frame never completes
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
   end

endmodule
